// ==== sim.f ====
risc5_io_pkg.sv
io_decode.sv
ms_timer.sv
lsb_regs.sv
proc_timers.sv
risc5_io_top.sv
risc5_io_asserts.sv
tb_risc5_io.sv

// ==== Makefile ====
# Verilator build and run of the RISC5 I/O testbench

VERILATOR ?= verilator
TOP       ?= tb_risc5_io
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= Verification passed

.PHONY: sim clean

# build, run, then look for the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_risc5_io.sv ====
// --------------------------------------------------
// tb_risc5_io
// directed testbench for the RISC5 I/O block with
// decoding, ms timer, LED, input and process timer tests
// --------------------------------------------------

`timescale 1ns/10ps

module tb_risc5_io;

  localparam int clock_freq  = 40_000;
  localparam int clks_per_ms = clock_freq / 1000;
  localparam int half_ns     = 20;
  localparam int word_w      = risc5_io_pkg::word_w;
  localparam int adr_w       = risc5_io_pkg::adr_w;
  // ms waits of the timer test 1+2+5 and the process timers 3+2+6
  localparam int total_ms    = 19;
  localparam int watchdog_cycles = total_ms * clks_per_ms + 2000;

  logic                               clk = 1'b0;
  logic                               rst_n;
  logic [adr_w-1:0]                   adr;
  logic                               rd;
  logic                               wr;
  logic [word_w-1:0]                  outbus;
  logic [word_w-1:0]                  ram_data;
  logic [word_w-1:0]                  prom_data;
  logic [risc5_io_pkg::num_btn-1:0]   btn_n;
  logic [risc5_io_pkg::num_swi-1:0]   swi;
  logic                               ram_en;
  logic                               prom_en;
  logic [word_w-1:0]                  codebus;
  logic [word_w-1:0]                  inbus;
  logic [risc5_io_pkg::num_led_g-1:0] led_g;
  logic [risc5_io_pkg::num_led_r-1:0] led_r;

  int seed = 32'he3b9219f;
  int pass_cnt = 0;
  int fail_cnt = 0;

  risc5_io_top #(.clock_freq(clock_freq)) UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .adr       (adr),
    .rd        (rd),
    .wr        (wr),
    .outbus    (outbus),
    .ram_data  (ram_data),
    .prom_data (prom_data),
    .btn_n     (btn_n),
    .swi       (swi),
    .ram_en    (ram_en),
    .prom_en   (prom_en),
    .codebus   (codebus),
    .inbus     (inbus),
    .led_g     (led_g),
    .led_r     (led_r)
  );

  // 40 ns clock
  always #half_ns clk = ~clk;

  // --------------------------------------------------
  // compare tasks
  task automatic check_word(input string name, input logic [word_w-1:0] exp,
                            input logic [word_w-1:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  task automatic check_leds(input string name,
                            input logic [risc5_io_pkg::num_led_g-1:0] exp_g,
                            input logic [risc5_io_pkg::num_led_r-1:0] exp_r);
    if ({led_g, led_r} !== {exp_g, exp_r}) begin
      $display("CHECK FAILED %s: expected g=%h r=%h, actual g=%h r=%h",
               name, exp_g, exp_r, led_g, led_r);
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  function automatic void report_test(input string name, input int f0);
    $display("test %s finished, %0d errors", name, fail_cnt - f0);
  endfunction

  // --------------------------------------------------
  // bus tasks entered and left 2 ns after a rising edge
  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
  endtask

  task automatic io_write(input logic [7:0] ofs, input logic [word_w-1:0] data);
    adr    = {risc5_io_pkg::io_prefix, ofs};
    wr     = 1'b1;
    outbus = data;
    @(posedge clk);
    #2;
    wr = 1'b0;
  endtask

  task automatic io_read(input logic [7:0] ofs, output logic [word_w-1:0] data);
    adr = {risc5_io_pkg::io_prefix, ofs};
    rd  = 1'b1;
    // sampled mid cycle
    @(negedge clk);
    data = inbus;
    @(posedge clk);
    #2;
    rd = 1'b0;
  endtask

  // next bus cycle starts ms milliseconds after the last one
  task automatic wait_ms(input int ms);
    repeat (ms * clks_per_ms - 1) @(posedge clk);
    #2;
  endtask

  // timer select in [2:0] and period in [31:16]
  function automatic logic [word_w-1:0] ptmr_cfg(input logic [2:0] sel,
                                                 input logic [15:0] period);
    return {period, 13'd0, sel};
  endfunction

  // --------------------------------------------------
  // directed tests
  task automatic decode_at(input string name, input logic [adr_w-1:0] a,
                           input logic exp_ram, input logic exp_prom,
                           input logic io_hole);
    logic [word_w-1:0] exp_code;
    logic [word_w-1:0] exp_in;
    adr       = a;
    rd        = 1'b1;
    ram_data  = $random(seed);
    prom_data = $random(seed);
    // code from PROM in its window and data from RAM unless I/O
    exp_code  = exp_prom ? prom_data : ram_data;
    exp_in    = io_hole ? '0 : ram_data;
    @(negedge clk);
    check_bit({name, " ram_en"}, exp_ram, ram_en);
    check_bit({name, " prom_en"}, exp_prom, prom_en);
    check_word({name, " codebus"}, exp_code, codebus);
    check_word({name, " inbus"}, exp_in, inbus);
    @(posedge clk);
    #2;
    rd = 1'b0;
  endtask

  task automatic decode_map();
    int f0;
    f0 = fail_cnt;
    decode_at("decode ram", 24'h001000, 1'b1, 1'b0, 1'b0);
    decode_at("decode prom base", risc5_io_pkg::prom_base, 1'b0, 1'b1, 1'b0);
    decode_at("decode prom top", 24'hFFE7FC, 1'b0, 1'b1, 1'b0);
    decode_at("decode above prom", 24'hFFE800, 1'b0, 1'b0, 1'b0);
    decode_at("decode gap", 24'hFFF000, 1'b0, 1'b0, 1'b0);
    decode_at("decode io hole 00", 24'hFFFF00, 1'b0, 1'b0, 1'b1);
    decode_at("decode io hole 80", 24'hFFFF80, 1'b0, 1'b0, 1'b1);
    report_test("decode", f0);
  endtask

  task automatic ms_count_steps();
    int f0;
    int steps [3];
    logic [word_w-1:0] t0;
    logic [word_w-1:0] t1;
    f0    = fail_cnt;
    steps = '{1, 2, 5};
    foreach (steps[i]) begin
      io_read(risc5_io_pkg::io_tmr_ofs, t0);
      wait_ms(steps[i]);
      io_read(risc5_io_pkg::io_tmr_ofs, t1);
      check_word($sformatf("ms timer %0d ms", steps[i]), steps[i], t1 - t0);
    end
    report_test("ms timer", f0);
  endtask

  task automatic led_writes();
    int f0;
    logic [word_w-1:0] w;
    f0 = fail_cnt;
    repeat (4) begin
      w = $random(seed);
      io_write(risc5_io_pkg::io_lsb_ofs, w);
      // green in [7:0] and red in [17:8]
      check_leds("leds write", w[7:0], w[17:8]);
    end
    apply_reset();
    check_leds("leds after reset", '0, '0);
    report_test("leds", f0);
  endtask

  task automatic input_sync();
    int f0;
    logic [word_w-1:0] rnd;
    logic [word_w-1:0] r;
    f0 = fail_cnt;
    repeat (4) begin
      rnd   = $random(seed);
      btn_n = rnd[3:0];
      swi   = rnd[13:4];
      repeat (3) @(posedge clk);
      #2;
      io_read(risc5_io_pkg::io_lsb_ofs, r);
      // switches in [13:4] and active high buttons in [3:0]
      check_word("buttons and switches", {18'd0, rnd[13:4], ~rnd[3:0]}, r);
    end
    report_test("buttons and switches", f0);
  endtask

  task automatic periodic_ready();
    int f0;
    logic [word_w-1:0] t0;
    logic [word_w-1:0] t1;
    logic [word_w-1:0] r;
    f0 = fail_cnt;
    // line up with a ms tick so set edges are known
    io_read(risc5_io_pkg::io_tmr_ofs, t0);
    do begin
      io_read(risc5_io_pkg::io_tmr_ofs, t1);
    end while (t1 == t0);
    io_write(risc5_io_pkg::io_ptmr_ofs, ptmr_cfg(3'd2, 16'd3));
    io_write(risc5_io_pkg::io_ptmr_ofs, ptmr_cfg(3'd5, 16'd5));
    // 3 ms plus half a ms
    wait_ms(3);
    repeat (clks_per_ms / 2) @(posedge clk);
    #2;
    io_read(risc5_io_pkg::io_ptmr_ofs, r);
    check_word("ptimers at 3 ms", 32'h04, r);
    io_read(risc5_io_pkg::io_ptmr_ofs, r);
    check_word("ptimers cleared", 32'h00, r);
    wait_ms(2);
    io_read(risc5_io_pkg::io_ptmr_ofs, r);
    check_word("ptimers at 5 ms", 32'h20, r);
    // timer 5 off while timer 2 keeps running
    io_write(risc5_io_pkg::io_ptmr_ofs, ptmr_cfg(3'd5, 16'd0));
    wait_ms(6);
    io_read(risc5_io_pkg::io_ptmr_ofs, r);
    check_bit("ptimer 5 disabled", 1'b0, r[5]);
    report_test("process timers", f0);
  endtask

  // --------------------------------------------------
  // main sequence
  initial begin
    rst_n     = 1'b0;
    adr       = '0;
    rd        = 1'b0;
    wr        = 1'b0;
    outbus    = '0;
    ram_data  = '0;
    prom_data = '0;
    btn_n     = '1;
    swi       = '0;
    apply_reset();
    decode_map();
    ms_count_steps();
    led_writes();
    input_sync();
    periodic_ready();
    $display("checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // watchdog from the summed ms waits plus margin
  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: tests did not finish within %0d clock cycles", watchdog_cycles);
    $display("Verification failed");
    $finish;
  end

endmodule

// ==== risc5_io_asserts.sv ====
// --------------------------------------------------
// risc5_io_asserts
// bus strobe, ms tick and LED reset properties,
// bound into the I/O top level
// --------------------------------------------------

`timescale 1ns/10ps

module risc5_io_asserts (
  input logic                               clk,
  input logic                               rst_n,
  input logic                               tmr_stb,
  input logic                               lsb_stb,
  input logic                               ptmr_stb,
  input logic                               ms_tick,
  input logic [risc5_io_pkg::num_led_g-1:0] led_g,
  input logic [risc5_io_pkg::num_led_r-1:0] led_r
);

  // device strobes never overlap
  strobe_excl: assert property (@(posedge clk) $onehot0({tmr_stb, lsb_stb, ptmr_stb}))
    else $error("more than one device strobe high");

  // tick is a single cycle pulse
  tick_pulse: assert property (@(posedge clk) disable iff (!rst_n) ms_tick |=> !ms_tick)
    else $error("ms_tick high for two cycles");

  // LEDs cleared one edge after reset
  led_reset: assert property (@(posedge clk) !rst_n |=> (led_g == '0) && (led_r == '0))
    else $error("LED outputs not cleared by reset");

endmodule

bind risc5_io_top risc5_io_asserts asserts_0 (
  .clk      (clk),
  .rst_n    (rst_n),
  .tmr_stb  (tmr_stb),
  .lsb_stb  (lsb_stb),
  .ptmr_stb (ptmr_stb),
  .ms_tick  (ms_tick),
  .led_g    (led_g),
  .led_r    (led_r)
);

// ==== risc5_io_top.sv ====
// --------------------------------------------------
// risc5_io_top
// I/O side of the RISC5 system with the address
// decoder, ms timer, LED/switch register and
// process timers
// --------------------------------------------------

`timescale 1ns/10ps

module risc5_io_top #(
  parameter int clock_freq = 20_000_000
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [risc5_io_pkg::adr_w-1:0]     adr,
  input  logic                               rd,
  input  logic                               wr,
  input  logic [risc5_io_pkg::word_w-1:0]    outbus,
  input  logic [risc5_io_pkg::word_w-1:0]    ram_data,
  input  logic [risc5_io_pkg::word_w-1:0]    prom_data,
  input  logic [risc5_io_pkg::num_btn-1:0]   btn_n,
  input  logic [risc5_io_pkg::num_swi-1:0]   swi,
  output logic                               ram_en,
  output logic                               prom_en,
  output logic [risc5_io_pkg::word_w-1:0]    codebus,
  output logic [risc5_io_pkg::word_w-1:0]    inbus,
  output logic [risc5_io_pkg::num_led_g-1:0] led_g,
  output logic [risc5_io_pkg::num_led_r-1:0] led_r
);

  // device strobes and read words
  logic                            tmr_stb;
  logic                            lsb_stb;
  logic                            ptmr_stb;
  logic                            ms_tick;
  logic [risc5_io_pkg::word_w-1:0] tmr_data;
  logic [risc5_io_pkg::word_w-1:0] lsb_data;
  logic [risc5_io_pkg::word_w-1:0] ptmr_data;

  // address decoding and read muxes
  io_decode decode_0 (
    .adr       (adr),
    .rd        (rd),
    .ram_data  (ram_data),
    .prom_data (prom_data),
    .tmr_data  (tmr_data),
    .lsb_data  (lsb_data),
    .ptmr_data (ptmr_data),
    .ram_en    (ram_en),
    .prom_en   (prom_en),
    .tmr_stb   (tmr_stb),
    .lsb_stb   (lsb_stb),
    .ptmr_stb  (ptmr_stb),
    .codebus   (codebus),
    .inbus     (inbus)
  );

  // ms timer at -64
  ms_timer #(.clock_freq(clock_freq)) tmr_0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .ms_tick  (ms_tick),
    .ms_count (tmr_data)
  );

  // LEDs, switches and buttons at -60
  lsb_regs lsb_0 (
    .clk   (clk),
    .rst_n (rst_n),
    .stb   (lsb_stb),
    .wr    (wr),
    .wdata (outbus),
    .btn_n (btn_n),
    .swi   (swi),
    .led_g (led_g),
    .led_r (led_r),
    .rdata (lsb_data)
  );

  // process periodic timers at -132
  proc_timers ptmr_0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .stb     (ptmr_stb),
    .rd      (rd),
    .wr      (wr),
    .ms_tick (ms_tick),
    .wdata   (outbus),
    .rdata   (ptmr_data)
  );

endmodule

// ==== proc_timers.sv ====
// --------------------------------------------------
// proc_timers
// periodic millisecond timers for processes, each
// with a sticky ready bit, cleared by a read
// --------------------------------------------------

`timescale 1ns/10ps

module proc_timers (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            stb,
  input  logic                            rd,
  input  logic                            wr,
  input  logic                            ms_tick,
  input  logic [risc5_io_pkg::word_w-1:0] wdata,
  output logic [risc5_io_pkg::word_w-1:0] rdata
);

  localparam int n     = risc5_io_pkg::num_ptimers;
  localparam int per_w = risc5_io_pkg::ptmr_period_w;
  localparam int sel_w = $clog2(n);

  logic [per_w-1:0] period [n];
  logic [per_w-1:0] cnt    [n];
  logic [n-1:0]     ready;
  logic [n-1:0]     hit;
  logic             wr_en;
  logic             rd_clr;
  logic [sel_w-1:0] sel;

  assign wr_en  = stb && wr;
  assign rd_clr = stb && rd;
  // timer number in wdata[2:0]
  assign sel    = wdata[sel_w-1:0];

  // --------------------------------------------------
  // period reached on this tick
  // zero period means the timer is off
  always_comb begin
    for (int i = 0; i < n; i++) begin
      hit[i] = ms_tick && (period[i] != '0) && (cnt[i] == period[i] - per_w'(1));
    end
  end

  // --------------------------------------------------
  // counters, periods and ready bits
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < n; i++) begin
        period[i] <= '0;
        cnt[i]    <= '0;
      end
      ready <= '0;
    end else begin
      for (int i = 0; i < n; i++) begin
        if (hit[i]) begin
          // set beats a read on the same edge
          ready[i] <= 1'b1;
          cnt[i]   <= '0;
        end else begin
          if (ms_tick && (period[i] != '0)) begin
            cnt[i] <= cnt[i] + 1'b1;
          end
          if (rd_clr) begin
            ready[i] <= 1'b0;
          end
        end
        // new period in wdata[31:16], restarts the count
        if (wr_en && (sel == sel_w'(i))) begin
          period[i] <= wdata[risc5_io_pkg::word_w-1 -: per_w];
          cnt[i]    <= '0;
        end
      end
    end
  end

  assign rdata = {{(risc5_io_pkg::word_w - n){1'b0}}, ready};

endmodule

// ==== lsb_regs.sv ====
// --------------------------------------------------
// lsb_regs
// green/red LED register, buttons and switches
// through two-stage synchronizers on the read side
// --------------------------------------------------

`timescale 1ns/10ps

module lsb_regs (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               stb,
  input  logic                               wr,
  input  logic [risc5_io_pkg::word_w-1:0]    wdata,
  input  logic [risc5_io_pkg::num_btn-1:0]   btn_n,
  input  logic [risc5_io_pkg::num_swi-1:0]   swi,
  output logic [risc5_io_pkg::num_led_g-1:0] led_g,
  output logic [risc5_io_pkg::num_led_r-1:0] led_r,
  output logic [risc5_io_pkg::word_w-1:0]    rdata
);

  // zero fill above switches and buttons
  localparam int pad_w = risc5_io_pkg::word_w - risc5_io_pkg::num_swi
                         - risc5_io_pkg::num_btn;

  logic [risc5_io_pkg::num_btn-1:0] btn_s1;
  logic [risc5_io_pkg::num_btn-1:0] btn_s2;
  logic [risc5_io_pkg::num_swi-1:0] swi_s1;
  logic [risc5_io_pkg::num_swi-1:0] swi_s2;

  // --------------------------------------------------
  // LED register
  // green in wdata[7:0], red in wdata[17:8]
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      led_g <= '0;
      led_r <= '0;
    end else if (stb && wr) begin
      led_g <= wdata[risc5_io_pkg::num_led_g-1:0];
      led_r <= wdata[risc5_io_pkg::num_led_g +: risc5_io_pkg::num_led_r];
    end
  end

  // --------------------------------------------------
  // input synchronizers
  // buttons are active low on the board
  always_ff @(posedge clk) begin
    btn_s1 <= ~btn_n;
    btn_s2 <= btn_s1;
  end

  always_ff @(posedge clk) begin
    swi_s1 <= swi;
    swi_s2 <= swi_s1;
  end

  // switches in [13:4], buttons in [3:0]
  assign rdata = {{pad_w{1'b0}}, swi_s2, btn_s2};

endmodule

// ==== ms_timer.sv ====
// --------------------------------------------------
// ms_timer
// millisecond prescaler with a one-cycle tick and
// a running millisecond count since reset
// --------------------------------------------------

`timescale 1ns/10ps

module ms_timer #(
  parameter int clock_freq = 20_000_000
) (
  input  logic                            clk,
  input  logic                            rst_n,
  output logic                            ms_tick,
  output logic [risc5_io_pkg::word_w-1:0] ms_count
);

  // clocks per millisecond
  localparam int div     = clock_freq / 1000;
  localparam int presc_w = (div > 1) ? $clog2(div) : 1;

  logic [presc_w-1:0] presc;

  // --------------------------------------------------
  // tick on the last prescaler state
  // prescaler wraps and count steps on the same edge
  assign ms_tick = (presc == presc_w'(div - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      presc <= '0;
    end else if (ms_tick) begin
      presc <= '0;
    end else begin
      presc <= presc + 1'b1;
    end
  end

  // --------------------------------------------------
  // elapsed milliseconds, also the read word
  // wraps after about 49 days
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ms_count <= '0;
    end else if (ms_tick) begin
      ms_count <= ms_count + 1'b1;
    end
  end

endmodule

// ==== io_decode.sv ====
// --------------------------------------------------
// io_decode
// memory map decoding of the RAM/PROM/I/O strobes,
// the codebus and inbus selection and the I/O read mux
// --------------------------------------------------

`timescale 1ns/10ps

module io_decode (
  input  logic [risc5_io_pkg::adr_w-1:0]  adr,
  input  logic                            rd,
  input  logic [risc5_io_pkg::word_w-1:0] ram_data,
  input  logic [risc5_io_pkg::word_w-1:0] prom_data,
  input  logic [risc5_io_pkg::word_w-1:0] tmr_data,
  input  logic [risc5_io_pkg::word_w-1:0] lsb_data,
  input  logic [risc5_io_pkg::word_w-1:0] ptmr_data,
  output logic                            ram_en,
  output logic                            prom_en,
  output logic                            tmr_stb,
  output logic                            lsb_stb,
  output logic                            ptmr_stb,
  output logic [risc5_io_pkg::word_w-1:0] codebus,
  output logic [risc5_io_pkg::word_w-1:0] inbus
);

  logic                            io_en;
  logic [risc5_io_pkg::word_w-1:0] io_rdata;

  // --------------------------------------------------
  // region strobes
  // everything below the top 8 kB is RAM
  assign ram_en = (adr[risc5_io_pkg::adr_w-1:risc5_io_pkg::ram_top_lsb]
                   != risc5_io_pkg::ram_top_prefix);

  // 2 kB boot PROM window at the CPU start address
  assign prom_en = (adr[risc5_io_pkg::adr_w-1:risc5_io_pkg::prom_win_w]
                    == risc5_io_pkg::prom_base[risc5_io_pkg::adr_w-1:risc5_io_pkg::prom_win_w]);

  // 256 byte I/O block of 64 words
  assign io_en = (adr[risc5_io_pkg::adr_w-1:risc5_io_pkg::io_blk_w]
                  == risc5_io_pkg::io_prefix);

  // --------------------------------------------------
  // device strobes, one word each
  // word granular match with byte lanes ignored
  assign tmr_stb  = io_en && (adr[7:2] == risc5_io_pkg::io_tmr_ofs[7:2]);
  assign lsb_stb  = io_en && (adr[7:2] == risc5_io_pkg::io_lsb_ofs[7:2]);
  assign ptmr_stb = io_en && (adr[7:2] == risc5_io_pkg::io_ptmr_ofs[7:2]);

  // --------------------------------------------------
  // I/O read mux
  // unmapped words and idle cycles read as zero
  always_comb begin
    io_rdata = '0;
    if (rd) begin
      if (tmr_stb) begin
        io_rdata = tmr_data;
      end else if (lsb_stb) begin
        io_rdata = lsb_data;
      end else if (ptmr_stb) begin
        io_rdata = ptmr_data;
      end
    end
  end

  // code fetches from PROM while in its window
  assign codebus = prom_en ? prom_data : ram_data;

  // data reads from the I/O block or RAM
  assign inbus = io_en ? io_rdata : ram_data;

endmodule

// ==== risc5_io_pkg.sv ====
// --------------------------------------------------
// risc5_io_pkg
// bus widths, memory map and I/O offsets shared by
// the decoder, the devices and the top level
// --------------------------------------------------

package risc5_io_pkg;

  // bus widths
  parameter int adr_w  = 24;
  parameter int word_w = 32;

  // --------------------------------------------------
  // memory map
  // top 8 kB hold PROM, a gap and the I/O blocks
  parameter logic [23:0] prom_base   = 24'hFFE000;
  // PROM window is 2 kB, so 11 offset bits
  parameter int          prom_win_w  = 11;
  // adr[23:13] of the top 8 kB
  parameter int          ram_top_lsb = 13;
  parameter logic [10:0] ram_top_prefix = 11'h7FF;
  // one 256 byte I/O block at 0FFFF00H
  parameter int          io_blk_w  = 8;
  parameter logic [15:0] io_prefix = 16'hFFFF;

  // --------------------------------------------------
  // byte offsets inside the I/O block
  parameter logic [7:0] io_tmr_ofs  = 8'hC0;  // -64
  parameter logic [7:0] io_lsb_ofs  = 8'hC4;  // -60
  parameter logic [7:0] io_ptmr_ofs = 8'h7C;  // -132

  // board I/O counts
  parameter int num_led_g = 8;
  parameter int num_led_r = 10;
  parameter int num_btn   = 4;
  parameter int num_swi   = 10;

  // process timers
  parameter int num_ptimers   = 8;
  parameter int ptmr_period_w = 16;

endpackage
